// ==== hw/alpha_pkg.sv ====
`default_nettype none

package alpha_pkg;

	////////////////////////////////////////////////////////////
	// widths and fixed values
	////////////////////////////////////////////////////////////

	localparam int XLEN = 64;                     // datapath width
	localparam logic [4:0] ZERO_REG = 5'd31;      // r31 reads as zero, no writeback

	// PAL function field, inst[25:0]
	localparam logic [25:0] PAL_HALT  = 26'h555;
	localparam logic [25:0] PAL_WHAMI = 26'h03c;  // cpuid into ra

	////////////////////////////////////////////////////////////
	// primary opcodes, inst[31:26]
	////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_PAL   = 6'h00,
		OP_LDA   = 6'h08,
		OP_INTA  = 6'h10,  // integer arith
		OP_INTL  = 6'h11,  // integer logical
		OP_INTS  = 6'h12,  // shifts
		OP_INTM  = 6'h13,  // multiply
		OP_ITFP  = 6'h14,
		OP_FLTV  = 6'h15,
		OP_FLTI  = 6'h16,
		OP_FLTL  = 6'h17,
		OP_MISC  = 6'h18,
		OP_JSR   = 6'h1a,  // jmp/jsr/ret/jsr_co share this one
		OP_FTPI  = 6'h1c,
		OP_LDQ   = 6'h29,
		OP_LDQ_L = 6'h2b,
		OP_STQ   = 6'h2d,
		OP_STQ_C = 6'h2f,
		OP_BR    = 6'h30,
		OP_FBEQ  = 6'h31,
		OP_FBLT  = 6'h32,
		OP_FBLE  = 6'h33,
		OP_BSR   = 6'h34,
		OP_FBNE  = 6'h35,
		OP_FBGE  = 6'h36,
		OP_FBGT  = 6'h37,
		OP_BLBC  = 6'h38,
		OP_BEQ   = 6'h39,
		OP_BLT   = 6'h3a,
		OP_BLE   = 6'h3b,
		OP_BLBS  = 6'h3c,
		OP_BNE   = 6'h3d,
		OP_BGE   = 6'h3e,
		OP_BGT   = 6'h3f
	} op_e;

	////////////////////////////////////////////////////////////
	// ALU functions and operand mux selects
	////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		ALU_ADDQ   = 5'h00,  // also the no-op default
		ALU_SUBQ   = 5'h01,
		ALU_AND    = 5'h02,
		ALU_BIC    = 5'h03,
		ALU_BIS    = 5'h04,
		ALU_ORNOT  = 5'h05,
		ALU_XOR    = 5'h06,
		ALU_EQV    = 5'h07,
		ALU_SRL    = 5'h08,
		ALU_SLL    = 5'h09,
		ALU_SRA    = 5'h0a,
		ALU_MULQ   = 5'h0b,
		ALU_CMPEQ  = 5'h0c,
		ALU_CMPLT  = 5'h0d,
		ALU_CMPLE  = 5'h0e,
		ALU_CMPULT = 5'h0f,
		ALU_CMPULE = 5'h10
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_REGA     = 2'd0,  // tag, goes to rename
		OPA_MEM_DISP = 2'd1,
		OPA_NPC      = 2'd2,
		OPA_NOT3     = 2'd3   // word align mask for jumps
	} opa_sel_e;

	typedef enum logic [1:0] {
		OPB_REGB    = 2'd0,
		OPB_ALU_IMM = 2'd1,
		OPB_BR_DISP = 2'd2
	} opb_sel_e;

	typedef enum logic [1:0] {
		DEST_NONE = 2'd0,
		DEST_REGA = 2'd1,
		DEST_REGC = 2'd2
	} dest_sel_e;

	// function codes, inst[11:5], per group
	localparam logic [6:0] FN_ADDQ   = 7'h20;  // INTA
	localparam logic [6:0] FN_SUBQ   = 7'h29;
	localparam logic [6:0] FN_CMPEQ  = 7'h2d;
	localparam logic [6:0] FN_CMPLT  = 7'h4d;
	localparam logic [6:0] FN_CMPLE  = 7'h6d;
	localparam logic [6:0] FN_CMPULT = 7'h1d;
	localparam logic [6:0] FN_CMPULE = 7'h3d;
	localparam logic [6:0] FN_AND    = 7'h00;  // INTL
	localparam logic [6:0] FN_BIC    = 7'h08;
	localparam logic [6:0] FN_BIS    = 7'h20;
	localparam logic [6:0] FN_ORNOT  = 7'h28;
	localparam logic [6:0] FN_XOR    = 7'h40;
	localparam logic [6:0] FN_EQV    = 7'h48;
	localparam logic [6:0] FN_SRL    = 7'h34;  // INTS
	localparam logic [6:0] FN_SLL    = 7'h39;
	localparam logic [6:0] FN_SRA    = 7'h3c;
	localparam logic [6:0] FN_MULQ   = 7'h20;  // INTM

endpackage

`default_nettype wire

// ==== hw/id_ifs.sv ====
`default_nettype none

// decoder outputs for one slot
interface decode_ctrl_if import alpha_pkg::*; ();
	opa_sel_e  opa_sel;
	opb_sel_e  opb_sel;
	dest_sel_e dest_sel;
	alu_func_e alu_func;
	logic      rd_mem, wr_mem, ldl_mem, stc_mem;  // memory class
	logic      cond_branch, uncond_branch;
	logic      halt, cpuid, illegal, valid;

	modport decoder (output opa_sel, opb_sel, dest_sel, alu_func, rd_mem, wr_mem,
		ldl_mem, stc_mem, cond_branch, uncond_branch, halt, cpuid, illegal, valid);
	modport select (input opa_sel, opb_sel, dest_sel);  // mux selects only
	modport stage (input alu_func, rd_mem, wr_mem, ldl_mem, stc_mem, cond_branch,
		uncond_branch, halt, cpuid, illegal, valid);
endinterface

// operand values or tags for one slot
interface operand_bus_if import alpha_pkg::*; ();
	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic            opa_is_value;  // 0 means opa holds a reg index
	logic            opb_is_value;
	logic [4:0]      dest_idx;

	modport source (output opa, opb, opa_is_value, opb_is_value, dest_idx);
	modport sink (input opa, opb, opa_is_value, opb_is_value, dest_idx);
endinterface

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`default_nettype none

// one slot of decode, pure PLA
module inst_decoder import alpha_pkg::*; (
	input wire [31:0] inst,
	input wire        valid_in,  // low means output no-op defaults
	decode_ctrl_if.decoder ctrl
);

	op_e       op;
	logic [6:0] fn;       // function code for operate format
	alu_func_e int_func;  // lookup result for integer groups
	logic      int_ok;    // function code known in its group

	assign op = op_e'(inst[31:26]);
	assign fn = inst[11:5];

	////////////////////////////////////////////////////////////
	// integer operate lookup
	////////////////////////////////////////////////////////////

	always_comb begin
		int_func = ALU_ADDQ;
		int_ok = 1'b1;
		case (op)
			OP_INTA: begin
				case (fn)
					FN_ADDQ:   int_func = ALU_ADDQ;
					FN_SUBQ:   int_func = ALU_SUBQ;
					FN_CMPEQ:  int_func = ALU_CMPEQ;
					FN_CMPLT:  int_func = ALU_CMPLT;
					FN_CMPLE:  int_func = ALU_CMPLE;
					FN_CMPULT: int_func = ALU_CMPULT;
					FN_CMPULE: int_func = ALU_CMPULE;
					default:   int_ok = 1'b0;  // scaled adds etc
				endcase
			end
			OP_INTL: begin
				case (fn)
					FN_AND:   int_func = ALU_AND;
					FN_BIC:   int_func = ALU_BIC;
					FN_BIS:   int_func = ALU_BIS;
					FN_ORNOT: int_func = ALU_ORNOT;
					FN_XOR:   int_func = ALU_XOR;
					FN_EQV:   int_func = ALU_EQV;
					default:  int_ok = 1'b0;  // cmov not supported
				endcase
			end
			OP_INTS: begin
				case (fn)
					FN_SRL:  int_func = ALU_SRL;
					FN_SLL:  int_func = ALU_SLL;
					FN_SRA:  int_func = ALU_SRA;
					default: int_ok = 1'b0;  // byte manipulation
				endcase
			end
			OP_INTM: begin
				if (fn == FN_MULQ)
					int_func = ALU_MULQ;
				else
					int_ok = 1'b0;
			end
			default: int_ok = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// main decode by opcode
	////////////////////////////////////////////////////////////

	always_comb begin
		// no-op unless overridden below
		ctrl.opa_sel = OPA_REGA;
		ctrl.opb_sel = OPB_REGB;
		ctrl.dest_sel = DEST_NONE;
		ctrl.alu_func = ALU_ADDQ;
		ctrl.rd_mem = 1'b0;
		ctrl.wr_mem = 1'b0;
		ctrl.ldl_mem = 1'b0;
		ctrl.stc_mem = 1'b0;
		ctrl.cond_branch = 1'b0;
		ctrl.uncond_branch = 1'b0;
		ctrl.halt = 1'b0;
		ctrl.cpuid = 1'b0;
		ctrl.illegal = 1'b0;
		if (valid_in) begin
			case (op)
				OP_PAL: begin
					if (inst[25:0] == PAL_HALT) begin
						ctrl.halt = 1'b1;
					end else if (inst[25:0] == PAL_WHAMI) begin
						ctrl.cpuid = 1'b1;
						ctrl.dest_sel = DEST_REGA;  // cpu id lands in ra
					end else begin
						ctrl.illegal = 1'b1;  // other PAL calls
					end
				end
				OP_INTA, OP_INTL, OP_INTS, OP_INTM: begin
					if (int_ok) begin
						ctrl.opb_sel = inst[12] ? OPB_ALU_IMM : OPB_REGB;  // literal form
						ctrl.dest_sel = DEST_REGC;
						ctrl.alu_func = int_func;
					end else begin
						ctrl.illegal = 1'b1;
					end
				end
				OP_LDA, OP_LDQ, OP_LDQ_L, OP_STQ, OP_STQ_C: begin
					// address = rb + sign extended disp
					ctrl.opa_sel = OPA_MEM_DISP;
					ctrl.dest_sel = (op == OP_STQ) ? DEST_NONE : DEST_REGA;
					ctrl.rd_mem = (op == OP_LDQ) || (op == OP_LDQ_L);
					ctrl.ldl_mem = (op == OP_LDQ_L);
					ctrl.wr_mem = (op == OP_STQ) || (op == OP_STQ_C);
					ctrl.stc_mem = (op == OP_STQ_C);  // ra gets success flag
				end
				OP_JSR: begin
					ctrl.opa_sel = OPA_NOT3;
					ctrl.alu_func = ALU_AND;  // rb & ~3, word aligned target
					ctrl.dest_sel = DEST_REGA;  // return address
					ctrl.uncond_branch = 1'b1;
				end
				OP_BR, OP_BSR: begin
					ctrl.opa_sel = OPA_NPC;
					ctrl.opb_sel = OPB_BR_DISP;
					ctrl.dest_sel = DEST_REGA;
					ctrl.uncond_branch = 1'b1;
				end
				OP_BLBC, OP_BEQ, OP_BLT, OP_BLE, OP_BLBS, OP_BNE, OP_BGE, OP_BGT: begin
					ctrl.opa_sel = OPA_NPC;  // target = npc + disp*4
					ctrl.opb_sel = OPB_BR_DISP;
					ctrl.cond_branch = 1'b1;
				end
				OP_ITFP, OP_FLTV, OP_FLTI, OP_FLTL, OP_MISC, OP_FTPI,
				OP_FBEQ, OP_FBLT, OP_FBLE, OP_FBNE, OP_FBGE, OP_FBGT:
					ctrl.illegal = 1'b1;  // no fp, no misc
				default: ctrl.illegal = 1'b1;  // unknown opcode
			endcase
		end
	end

	// halt and illegal never count as valid, fetch stops on these
	assign ctrl.valid = valid_in & ~ctrl.illegal & ~ctrl.halt;

endmodule

`default_nettype wire

// ==== hw/operand_select.sv ====
`default_nettype none

// immediates plus opa/opb/dest muxes for one slot
module operand_select import alpha_pkg::*; (
	input wire [31:0]     inst,
	input wire [XLEN-1:0] npc,  // pc + 4 of this slot
	decode_ctrl_if.select ctrl,
	operand_bus_if.source ops
);

	logic [4:0]      ra_idx;
	logic [4:0]      rb_idx;
	logic [4:0]      rc_idx;
	logic [XLEN-1:0] mem_disp;
	logic [XLEN-1:0] br_disp;
	logic [XLEN-1:0] alu_imm;

	// register fields of this slot's own instruction
	assign ra_idx = inst[25:21];
	assign rb_idx = inst[20:16];
	assign rc_idx = inst[4:0];

	assign mem_disp = {{(XLEN-16){inst[15]}}, inst[15:0]};         // sext 16
	assign br_disp = {{(XLEN-23){inst[20]}}, inst[20:0], 2'b00};   // sext 21, x4
	assign alu_imm = {{(XLEN-8){1'b0}}, inst[20:13]};               // zext literal

	////////////////////////////////////////////////////////////
	// opa mux
	////////////////////////////////////////////////////////////

	always_comb begin
		case (ctrl.opa_sel)
			OPA_MEM_DISP: begin
				ops.opa = mem_disp;
				ops.opa_is_value = 1'b1;
			end
			OPA_NPC: begin
				ops.opa = npc;
				ops.opa_is_value = 1'b1;
			end
			OPA_NOT3: begin
				ops.opa = {{(XLEN-2){1'b1}}, 2'b00};  // ~3
				ops.opa_is_value = 1'b1;
			end
			default: begin
				ops.opa = {{(XLEN-5){1'b0}}, ra_idx};  // tag for rename
				ops.opa_is_value = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// opb mux, tag bit driven on every path
	////////////////////////////////////////////////////////////

	always_comb begin
		case (ctrl.opb_sel)
			OPB_ALU_IMM: begin
				ops.opb = alu_imm;
				ops.opb_is_value = 1'b1;
			end
			OPB_BR_DISP: begin
				ops.opb = br_disp;
				ops.opb_is_value = 1'b1;
			end
			default: begin
				ops.opb = {{(XLEN-5){1'b0}}, rb_idx};
				ops.opb_is_value = 1'b0;
			end
		endcase
	end

	// destination index
	always_comb begin
		case (ctrl.dest_sel)
			DEST_REGA: ops.dest_idx = ra_idx;
			DEST_REGC: ops.dest_idx = rc_idx;
			default:   ops.dest_idx = ZERO_REG;  // no writeback
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/id_dispatch_reg.sv ====
`default_nettype none

// ID/dispatch pipeline register, both slots
module id_dispatch_reg import alpha_pkg::*; (
	input wire        clock,
	input wire        rst_n,
	decode_ctrl_if.stage ctrl1,
	decode_ctrl_if.stage ctrl2,
	operand_bus_if.sink  ops1,
	operand_bus_if.sink  ops2,
	input wire [5:0]  op_type1,
	input wire [5:0]  op_type2,
	// slot 1
	output logic [XLEN-1:0] opa_1,
	output logic [XLEN-1:0] opb_1,
	output logic            opa_is_value_1,
	output logic            opb_is_value_1,
	output logic [4:0]      dest_idx_1,
	output alu_func_e       alu_func_1,
	output logic [5:0]      op_type_1,
	output logic            rd_mem_1,
	output logic            wr_mem_1,
	output logic            ldl_mem_1,
	output logic            stc_mem_1,
	output logic            cond_branch_1,
	output logic            uncond_branch_1,
	output logic            halt_1,
	output logic            cpuid_1,
	output logic            illegal_1,
	output logic            valid_1,
	// slot 2
	output logic [XLEN-1:0] opa_2,
	output logic [XLEN-1:0] opb_2,
	output logic            opa_is_value_2,
	output logic            opb_is_value_2,
	output logic [4:0]      dest_idx_2,
	output alu_func_e       alu_func_2,
	output logic [5:0]      op_type_2,
	output logic            rd_mem_2,
	output logic            wr_mem_2,
	output logic            ldl_mem_2,
	output logic            stc_mem_2,
	output logic            cond_branch_2,
	output logic            uncond_branch_2,
	output logic            halt_2,
	output logic            cpuid_2,
	output logic            illegal_2,
	output logic            valid_2
);

	logic       squash2;  // slot 1 halts, slot 2 must not issue
	logic [9:0] flags1;   // rd wr ldl stc cond uncond halt cpuid illegal valid
	logic [9:0] flags2;
	logic [4:0] dest2;

	assign squash2 = ctrl1.halt;

	assign flags1 = {ctrl1.rd_mem, ctrl1.wr_mem, ctrl1.ldl_mem, ctrl1.stc_mem,
		ctrl1.cond_branch, ctrl1.uncond_branch, ctrl1.halt, ctrl1.cpuid,
		ctrl1.illegal, ctrl1.valid};
	assign flags2 = squash2 ? '0 : {ctrl2.rd_mem, ctrl2.wr_mem, ctrl2.ldl_mem,
		ctrl2.stc_mem, ctrl2.cond_branch, ctrl2.uncond_branch, ctrl2.halt,
		ctrl2.cpuid, ctrl2.illegal, ctrl2.valid};
	assign dest2 = squash2 ? ZERO_REG : ops2.dest_idx;  // no writeback past halt

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			{opa_1, opb_1, opa_is_value_1, opb_is_value_1} <= '0;
			{opa_2, opb_2, opa_is_value_2, opb_is_value_2} <= '0;
			dest_idx_1 <= ZERO_REG;
			dest_idx_2 <= ZERO_REG;
			alu_func_1 <= ALU_ADDQ;
			alu_func_2 <= ALU_ADDQ;
			op_type_1 <= '0;
			op_type_2 <= '0;
			{rd_mem_1, wr_mem_1, ldl_mem_1, stc_mem_1, cond_branch_1, uncond_branch_1,
				halt_1, cpuid_1, illegal_1, valid_1} <= '0;
			{rd_mem_2, wr_mem_2, ldl_mem_2, stc_mem_2, cond_branch_2, uncond_branch_2,
				halt_2, cpuid_2, illegal_2, valid_2} <= '0;
		end else begin
			// slot 1 straight through
			{opa_1, opb_1, opa_is_value_1, opb_is_value_1} <=
				{ops1.opa, ops1.opb, ops1.opa_is_value, ops1.opb_is_value};
			dest_idx_1 <= ops1.dest_idx;
			alu_func_1 <= ctrl1.alu_func;
			op_type_1 <= op_type1;
			{rd_mem_1, wr_mem_1, ldl_mem_1, stc_mem_1, cond_branch_1, uncond_branch_1,
				halt_1, cpuid_1, illegal_1, valid_1} <= flags1;
			// slot 2, operands kept, control killed on squash
			{opa_2, opb_2, opa_is_value_2, opb_is_value_2} <=
				{ops2.opa, ops2.opb, ops2.opa_is_value, ops2.opb_is_value};
			dest_idx_2 <= dest2;
			alu_func_2 <= ctrl2.alu_func;
			op_type_2 <= op_type2;
			{rd_mem_2, wr_mem_2, ldl_mem_2, stc_mem_2, cond_branch_2, uncond_branch_2,
				halt_2, cpuid_2, illegal_2, valid_2} <= flags2;
		end
	end

endmodule

`default_nettype wire

// ==== hw/id_stage.sv ====
`default_nettype none

// two-wide decode stage, one cycle to dispatch
module id_stage import alpha_pkg::*; (
	input wire            clock,
	input wire            rst_n,
	input wire [31:0]     inst1,
	input wire            valid1,
	input wire [XLEN-1:0] npc1,
	input wire [31:0]     inst2,
	input wire            valid2,
	input wire [XLEN-1:0] npc2,
	// slot 1, registered
	output logic [XLEN-1:0] opa_1,
	output logic [XLEN-1:0] opb_1,
	output logic            opa_is_value_1,  // 1 value, 0 reg tag
	output logic            opb_is_value_1,
	output logic [4:0]      dest_idx_1,      // ZERO_REG when no writeback
	output alu_func_e       alu_func_1,
	output logic [5:0]      op_type_1,
	output logic            rd_mem_1,
	output logic            wr_mem_1,
	output logic            ldl_mem_1,
	output logic            stc_mem_1,
	output logic            cond_branch_1,
	output logic            uncond_branch_1,
	output logic            halt_1,
	output logic            cpuid_1,
	output logic            illegal_1,
	output logic            valid_1,
	// slot 2, registered
	output logic [XLEN-1:0] opa_2,
	output logic [XLEN-1:0] opb_2,
	output logic            opa_is_value_2,
	output logic            opb_is_value_2,
	output logic [4:0]      dest_idx_2,
	output alu_func_e       alu_func_2,
	output logic [5:0]      op_type_2,
	output logic            rd_mem_2,
	output logic            wr_mem_2,
	output logic            ldl_mem_2,
	output logic            stc_mem_2,
	output logic            cond_branch_2,
	output logic            uncond_branch_2,
	output logic            halt_2,
	output logic            cpuid_2,
	output logic            illegal_2,
	output logic            valid_2
);

	decode_ctrl_if ctrl1 ();
	decode_ctrl_if ctrl2 ();
	operand_bus_if ops1 ();
	operand_bus_if ops2 ();

	////////////////////////////////////////////////////////////
	// combinational decode, one lane per slot
	////////////////////////////////////////////////////////////

	inst_decoder u_dec1 (
		.inst(inst1),
		.valid_in(valid1),
		.ctrl(ctrl1.decoder)
	);

	inst_decoder u_dec2 (
		.inst(inst2),
		.valid_in(valid2),
		.ctrl(ctrl2.decoder)
	);

	operand_select u_sel1 (
		.inst(inst1),
		.npc(npc1),
		.ctrl(ctrl1.select),
		.ops(ops1.source)
	);

	operand_select u_sel2 (
		.inst(inst2),  // own fields for slot 2
		.npc(npc2),
		.ctrl(ctrl2.select),
		.ops(ops2.source)
	);

	// pipeline register, outputs hook up by name
	id_dispatch_reg u_reg (
		.ctrl1(ctrl1.stage),
		.ctrl2(ctrl2.stage),
		.ops1(ops1.sink),
		.ops2(ops2.sink),
		.op_type1(inst1[31:26]),  // op type is the raw opcode
		.op_type2(inst2[31:26]),
		.*
	);

endmodule

`default_nettype wire

// ==== verification/id_stage_asserts.sv ====
`default_nettype none

// output rules of the decode stage bound into id_stage
module id_stage_asserts (
	input wire clock,
	input wire rst_n,
	input wire valid_1, valid_2,
	input wire illegal_1, illegal_2,
	input wire rd_mem_1, rd_mem_2,
	input wire wr_mem_1, wr_mem_2,
	input wire ldl_mem_1, ldl_mem_2,
	input wire stc_mem_1, stc_mem_2,
	input wire cond_branch_1, cond_branch_2,
	input wire uncond_branch_1, uncond_branch_2,
	input wire halt_1, halt_2,
	input wire cpuid_1, cpuid_2
);

	logic any_ctrl;          // any control output of either slot
	int   fail_count = 0;    // number of assertion failures

	assign any_ctrl = valid_1 | valid_2 | illegal_1 | illegal_2 | rd_mem_1 | rd_mem_2 |
		wr_mem_1 | wr_mem_2 | ldl_mem_1 | ldl_mem_2 | stc_mem_1 | stc_mem_2 |
		cond_branch_1 | cond_branch_2 | uncond_branch_1 | uncond_branch_2 |
		halt_1 | halt_2 | cpuid_1 | cpuid_2;

	valid_not_illegal: assert property (@(posedge clock) disable iff (!rst_n)
		!(valid_1 && illegal_1) && !(valid_2 && illegal_2))
		else begin
			fail_count++;
			$error("valid and illegal high together");
		end

	load_not_store: assert property (@(posedge clock) disable iff (!rst_n)
		!(rd_mem_1 && wr_mem_1) && !(rd_mem_2 && wr_mem_2))
		else begin
			fail_count++;
			$error("rd_mem and wr_mem high together");
		end

	// nothing issues behind a halt
	halt_squash: assert property (@(posedge clock) disable iff (!rst_n)
		halt_1 |-> !valid_2)
		else begin
			fail_count++;
			$error("slot 2 valid while slot 1 halts");
		end

	reset_quiet: assert property (@(posedge clock) !rst_n |-> !any_ctrl)
		else begin
			fail_count++;
			$error("control output high during reset");
		end

endmodule

bind id_stage id_stage_asserts u_asserts (.*);

`default_nettype wire

// ==== verification/id_stage_tb.sv ====
`default_nettype none

// two-wide decode stage driven from a vector file
module id_stage_tb import alpha_pkg::*; ();

	logic            clock;
	logic            rst_n;
	logic [31:0]     inst1, inst2;
	logic            valid1, valid2;
	logic [XLEN-1:0] npc1, npc2;

	// registered dut outputs
	logic [XLEN-1:0] opa_1, opb_1, opa_2, opb_2;
	logic            opa_is_value_1, opb_is_value_1, opa_is_value_2, opb_is_value_2;
	logic [4:0]      dest_idx_1, dest_idx_2;
	alu_func_e       alu_func_1, alu_func_2;
	logic [5:0]      op_type_1, op_type_2;
	logic            rd_mem_1, wr_mem_1, ldl_mem_1, stc_mem_1;
	logic            rd_mem_2, wr_mem_2, ldl_mem_2, stc_mem_2;
	logic            cond_branch_1, uncond_branch_1, cond_branch_2, uncond_branch_2;
	logic            halt_1, cpuid_1, illegal_1, valid_1;
	logic            halt_2, cpuid_2, illegal_2, valid_2;

	// one row per pair with 6 stimulus columns and 6 expected per slot
	logic [63:0] rows [0:63][0:17];
	int          n_rows;
	bit          loaded;

	id_stage u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;  // period 4
	end

	//////////////////////////////////////////////////////////////
	// reporting
	//////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at time %0t: %s got %0h expected %0h",
				$time, what, got, exp));
	endtask

	//////////////////////////////////////////////////////////////
	// vector file
	//////////////////////////////////////////////////////////////

	task automatic load_vectors();
		int          fd;
		int          cnt;
		int          k;
		string       line;
		logic [63:0] f [0:17];
		fd = $fopen("verification/id_stage_input.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the vector file verification/id_stage_input.txt");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() >= 2 && line.getc(0) != "#") begin  // skip comments
					cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
						f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
					if (cnt != 18) begin
						abort_run($sformatf("vector file line has %0d fields, not 18", cnt));
					end else if (n_rows == 64) begin
						abort_run("vector file holds more rows than the table can take");
					end else begin
						for (k = 0; k < 18; k++)
							rows[n_rows][k] = f[k];
						n_rows++;
					end
				end
			end
			$fclose(fd);
			if (n_rows == 0)
				abort_run("vector file holds no rows");
		end
	endtask

	task automatic drive_row(input int r);
		inst1 = rows[r][0][31:0];
		valid1 = rows[r][1][0];
		npc1 = rows[r][2];
		inst2 = rows[r][3][31:0];
		valid2 = rows[r][4][0];
		npc2 = rows[r][5];
	endtask

	task automatic drive_idle();
		inst1 = '0;
		inst2 = '0;
		valid1 = 1'b0;
		valid2 = 1'b0;
		npc1 = '0;
		npc2 = '0;
	endtask

	//////////////////////////////////////////////////////////////
	// output checks
	//////////////////////////////////////////////////////////////

	// flags word from msb is rd wr ldl stc cond uncond halt cpuid illegal valid
	task automatic check_slot(input int r, input int slot);
		int          base;
		logic [31:0] ins;
		logic [63:0] g_alu, g_dest, g_opa, g_opb, g_isv, g_flags, g_type;
		string       tag;
		base = (slot == 1) ? 6 : 12;
		ins = (slot == 1) ? rows[r][0][31:0] : rows[r][3][31:0];
		tag = $sformatf("row %0d slot %0d", r + 1, slot);
		if (slot == 1) begin
			g_alu = alu_func_1;
			g_dest = dest_idx_1;
			g_opa = opa_1;
			g_opb = opb_1;
			g_isv = {opa_is_value_1, opb_is_value_1};
			g_flags = {rd_mem_1, wr_mem_1, ldl_mem_1, stc_mem_1, cond_branch_1,
				uncond_branch_1, halt_1, cpuid_1, illegal_1, valid_1};
			g_type = op_type_1;
		end else begin
			g_alu = alu_func_2;
			g_dest = dest_idx_2;
			g_opa = opa_2;
			g_opb = opb_2;
			g_isv = {opa_is_value_2, opb_is_value_2};
			g_flags = {rd_mem_2, wr_mem_2, ldl_mem_2, stc_mem_2, cond_branch_2,
				uncond_branch_2, halt_2, cpuid_2, illegal_2, valid_2};
			g_type = op_type_2;
		end
		check_val(g_alu, rows[r][base], {tag, " alu_func"});
		check_val(g_dest, rows[r][base + 1], {tag, " dest_idx"});
		check_val(g_opa, rows[r][base + 2], {tag, " opa"});
		check_val(g_opb, rows[r][base + 3], {tag, " opb"});
		check_val(g_isv, rows[r][base + 4], {tag, " is_value bits"});
		check_val(g_flags, rows[r][base + 5], {tag, " flags"});
		check_val(g_type, ins[31:26], {tag, " op_type"});  // raw opcode field
	endtask

	task automatic check_reset_state();
		check_val({rd_mem_1, wr_mem_1, ldl_mem_1, stc_mem_1, cond_branch_1, uncond_branch_1,
			halt_1, cpuid_1, illegal_1, valid_1}, '0, "reset slot 1 flags");
		check_val({rd_mem_2, wr_mem_2, ldl_mem_2, stc_mem_2, cond_branch_2, uncond_branch_2,
			halt_2, cpuid_2, illegal_2, valid_2}, '0, "reset slot 2 flags");
		check_val(dest_idx_1, ZERO_REG, "reset slot 1 dest_idx");
		check_val(dest_idx_2, ZERO_REG, "reset slot 2 dest_idx");
		check_val(opa_1 | opb_1, '0, "reset slot 1 operands");
		check_val(opa_2 | opb_2, '0, "reset slot 2 operands");
		check_val({opa_is_value_1, opb_is_value_1, opa_is_value_2, opb_is_value_2}, '0,
			"reset is_value bits");
		check_val({alu_func_1, alu_func_2, op_type_1, op_type_2}, '0,
			"reset alu_func and op_type");
	endtask

	//////////////////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////////////////

	initial begin : main_seq
		int i;
		rst_n = 1'b1;
		drive_idle();
		n_rows = 0;
		loaded = 1'b0;
		load_vectors();
		loaded = 1'b1;
		#1 rst_n = 1'b0;  // clean falling edge for the async reset
		repeat (3) @(posedge clock);
		#1;
		check_reset_state();
		rst_n = 1'b1;
		drive_row(0);
		// row i-1 was captured at this edge
		for (i = 1; i <= n_rows; i++) begin
			@(posedge clock);
			#1;
			check_slot(i - 1, 1);
			check_slot(i - 1, 2);
			if (i < n_rows)
				drive_row(i);
			else
				drive_idle();
		end
		$display("TEST PASS");
		$finish;
	end

	// bound assertions count their failures
	initial begin
		wait (u_dut.u_asserts.fail_count != 0);
		abort_run("a bound assertion on the DUT outputs failed");
	end

	initial begin
		wait (loaded);
		#((4 * n_rows + 20) * 4);  // cycles times period
		abort_run("watchdog expired before all vector rows were checked");
	end

endmodule

`default_nettype wire

// ==== id_stage.f ====
hw/alpha_pkg.sv
hw/id_ifs.sv
hw/inst_decoder.sv
hw/operand_select.sv
hw/id_dispatch_reg.sv
hw/id_stage.sv
verification/id_stage_asserts.sv
verification/id_stage_tb.sv

// ==== verification/id_stage_input.txt ====
# inst1 v1 npc1 inst2 v2 npc2, then per slot: alu dest opa opb isv flags (isv = opa,opb is_value)
# flags bits 9..0: rd wr ldl stc cond uncond halt cpuid illegal valid
40220403 0 104 40850526 0 108  00 1f 1 2 0 000  00 1f 4 5 0 000
40220403 1 104 40850526 1 108  00 03 1 2 0 001  01 06 4 5 0 001
44f4b008 1 10c 493ff72a 1 110  02 08 7 a5 1 001  09 0a 9 ff 1 001
4d6c040d 1 114 41cf0db0 1 118  0b 0d b c 0 001  0e 10 e f 0 001
20220010 1 11c a464fff8 1 120  00 01 10 2 2 001  00 03 fffffffffffffff8 4 2 201
aca60100 1 124 b4e87fff 1 128  00 05 100 6 2 281  00 1f 7fff 8 2 101
bd2a8000 1 12c 47e03405 1 130  00 09 ffffffffffff8000 a 2 141  04 05 1f 1 1 001
c3400004 1 1000 d35fffff 1 1004  00 1a 1000 10 3 011  00 1a 1004 fffffffffffffffc 3 011
e4200010 1 2000 f0500000 1 2004  00 1f 2000 40 3 021  00 1f 2004 ffffffffffc00000 3 021
6b5b4000 1 3000 fc600002 1 3004  02 1a fffffffffffffffc 1b 2 011  00 1f 3004 8 3 021
0000003c 1 3008 00000555 1 300c  00 00 0 0 0 005  00 1f 0 0 0 008
00000555 1 3010 40850526 1 3014  00 1f 0 0 0 008  01 1f 4 5 0 000
58220803 1 3018 60a64000 1 301c  00 1f 1 2 0 002  00 1f 5 6 0 002
04e80000 1 3020 412a004b 1 3024  00 1f 7 8 0 002  00 1f 9 a 0 002
00000083 1 3028 c4200010 1 302c  00 1f 0 0 0 002  00 1f 1 0 0 002
429015b5 1 4000 a464fff8 0 4004  0c 15 14 80 1 001  00 1f 3 4 0 000
48220783 1 4008 47dd091c 1 400c  0a 03 1 2 0 001  07 1c 1e 1d 0 001
00000555 1 4010 c3400004 1 4014  00 1f 0 0 0 008  00 1f 4014 10 3 000
